/* lm80c_glue.f */
common/lm80c_pkg.sv
bus/io_decode.sv
mem/mem_arbiter.sv
mem/boot_check.sv
hdl/lm80c_glue.sv
test/lm80c_glue_props.sv
test/tb_lm80c_glue.sv

/* run.sh */
#!/bin/sh
# Build and run the glue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
	--top-module tb_lm80c_glue \
	-f lm80c_glue.f \
	-o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
else
	exit 1
fi

/* test/tb_lm80c_glue.sv */
// Testbench for the glue top. Memory model is 64 bytes, answered combinationally.
// Inputs change 1 ns after the rising edge; combinational outputs checked 2 ns later.
`timescale 1ns/100ps
`default_nettype none

bind lm80c_glue lm80c_glue_props props0 (.*, .chk_busy_i(chk_req.busy));

module tb_lm80c_glue import lm80c_pkg::*; ();

	localparam int N_ROWS      = 17;
	localparam int WATCHDOG_NS = (N_ROWS * 4 + 200) * 4;

	typedef struct packed {
		cpu_bus_t   bus;
		dev_rdata_t rdat;
		mem_wr_t    dl;
		mem_wr_t    er;
		chip_sel_t  exp_sel;
		logic [7:0] exp_din;
		mem_req_t   exp_req;
		logic       exp_wait;
	} row_t;

	logic CLOCK, arst_n_i, boot_done_i, reset_key_i;
	cpu_bus_t   cpu_bus_i;
	dev_rdata_t dev_rdata_i;
	mem_wr_t    dl_i, er_i;
	logic [7:0] mem_rdata_i, cpu_din_o;
	chip_sel_t  chip_sel_o;
	mem_req_t   mem_req_o;
	logic       cpu_wait_o, sys_rst_n_o, sig_ok_o;

	logic [7:0] mem [0:63];
	row_t       rows [N_ROWS];
	integer     seed = 32'h405173fc;
	int         errors = 0;
	int         tests = 0;
	int         failed = 0;

	lm80c_glue dut0 (.*);

	assign mem_rdata_i = mem[mem_req_o.addr[5:0]];   // Combinational read

	initial begin
		CLOCK = 1'b0;
		forever #2 CLOCK = ~CLOCK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Test failures found");
		$display("Watchdog expired before the tests finished");
		$finish;
	end

	task automatic step();
		@(posedge CLOCK);
		#1;
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Finish one test and print its line
	task automatic report(input string name, input int err_before);
		tests++;
		if (errors != err_before) failed++;
		$display("%-28s %s", name, (errors == err_before) ? "ok" : "FAIL");
	endtask

	// Level of the status output being waited on
	function automatic logic status_level(input string name);
		return (name == "sig_ok_o") ? sig_ok_o : sys_rst_n_o;
	endfunction

	// Wait up to max_cycles for a status output to go high
	task automatic wait_high(input string name, input int max_cycles);
		int cycles;
		cycles = 0;
		while (status_level(name) !== 1'b1 && cycles < max_cycles) begin
			step();
			cycles++;
		end
		assert (status_level(name) === 1'b1) else begin
			$display("Timed out after %0d cycles waiting for %s to rise", cycles, name);
			errors++;
		end
	endtask

	// Expected outputs from the decode and priority rules
	function automatic row_t add_expected(input row_t r);
		logic [15:0] a;
		int          dev;
		a   = r.bus.addr;
		dev = 7;
		if (!r.bus.iorq_n && r.bus.mreq_n && a[7:4] <= 4'd4)
			dev = int'(a[7:4]);
		r.exp_sel.ctc_ce_n  = !(dev == 1);
		r.exp_sel.vdp_csr_n = !(dev == 3 && !r.bus.rd_n);
		r.exp_sel.vdp_csw_n = !(dev == 3 && !r.bus.wr_n);
		r.exp_sel.psg_bdir  = dev == 4 && !r.bus.wr_n;
		r.exp_sel.psg_bc    = dev == 4 && !a[0];
		r.exp_sel.vdp_mode  = a[1];
		if (r.dl.busy)
			r.exp_req = {r.dl.addr, r.dl.data, r.dl.wr, 1'b1};
		else if (r.er.busy)
			r.exp_req = {r.er.addr, r.er.data, r.er.wr, 1'b1};
		else
			r.exp_req = {9'd0, a, r.bus.dout, !r.bus.wr_n && !r.bus.mreq_n && a[15],
				!r.bus.rd_n && !r.bus.mreq_n};
		r.exp_wait = r.dl.busy | r.er.busy;   // boot_done_i high in table
		case (dev)
			1:       r.exp_din = r.rdat.ctc;
			3:       r.exp_din = r.rdat.vdp;
			4:       r.exp_din = r.rdat.psg;
			0, 2:    r.exp_din = 8'h00;
			default: r.exp_din = mem[r.exp_req.addr[5:0]];
		endcase
		return r;
	endfunction

	task automatic build_rows();
		int   nibs [10] = '{0, 1, 2, 3, 3, 4, 4, 5, 9, 1};
		row_t r;
		for (int i = 0; i < N_ROWS; i++) begin
			r = '0;
			r.bus = '{addr: 16'($random(seed)), dout: 8'($random(seed)),
				rd_n: 1'b1, wr_n: 1'b1, iorq_n: 1'b1, mreq_n: 1'b1};
			r.rdat = 24'($random(seed));
			r.dl   = {1'b0, 1'b1, 25'($random(seed)), 8'($random(seed))};
			r.er   = {1'b0, 1'b1, 25'($random(seed)), 8'($random(seed))};
			if (i < 10) begin   // I/O cycles
				r.bus.addr.io.dev = 4'(nibs[i]);
				r.bus.iorq_n      = 1'b0;
				if (i % 2 == 0 || i == 9) r.bus.rd_n = 1'b0;
				else                      r.bus.wr_n = 1'b0;
			end else begin      // Memory cycles
				r.bus.mreq_n = 1'b0;
				if (i == 10) r.bus.rd_n = 1'b0;
				else         r.bus.wr_n = 1'b0;
				r.bus.addr.mem.ram = (i == 12);
				r.dl.busy = (i == 13 || i == 15);
				r.er.busy = (i >= 14);
				if (i == 16) r.er.wr = 1'b0;
			end
			rows[i] = add_expected(r);
		end
	endtask

	initial begin
		int e0;
		arst_n_i    = 1'b0;
		boot_done_i = 1'b0;
		reset_key_i = 1'b0;
		cpu_bus_i   = '{addr: 16'h0, dout: 8'h0, rd_n: 1'b1, wr_n: 1'b1, iorq_n: 1'b1,
			mreq_n: 1'b1};
		dev_rdata_i = '0;
		dl_i        = '0;
		er_i        = '0;
		for (int i = 0; i < 64; i++)
			mem[i] = 8'(i * 37) ^ 8'hA5;   // Whole-address fill
		mem[0] = 8'hF3;
		mem[1] = 8'hC3;
		mem[2] = 8'h5A;
		mem[3] = 8'h02;
		repeat (3) @(posedge CLOCK);
		#1 arst_n_i = 1'b1;

		// Boot and signature
		e0 = errors;
		step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd0);
		check_val("cpu_wait_o", 64'(cpu_wait_o), 64'd1);   // Boot not done yet
		boot_done_i = 1'b1;
		wait_high("sys_rst_n_o", 10);
		wait_high("sig_ok_o", 6);
		report("signature good", e0);

		// Reset key and boot_done control
		e0 = errors;
		reset_key_i = 1'b1;
		step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd0);
		reset_key_i = 1'b0;
		step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd1);
		boot_done_i = 1'b0;
		step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd0);
		boot_done_i = 1'b1;
		step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd1);
		wait_high("sig_ok_o", 10);   // Checker reruns after reset
		report("reset control", e0);

		build_rows();
		foreach (rows[i]) begin
			e0 = errors;
			cpu_bus_i   = rows[i].bus;
			dev_rdata_i = rows[i].rdat;
			dl_i        = rows[i].dl;
			er_i        = rows[i].er;
			#2;
			check_val("chip_sel_o", 64'(chip_sel_o), 64'(rows[i].exp_sel));
			check_val("cpu_din_o", 64'(cpu_din_o), 64'(rows[i].exp_din));
			check_val("mem_req_o", 64'(mem_req_o), 64'(rows[i].exp_req));
			check_val("cpu_wait_o", 64'(cpu_wait_o), 64'(rows[i].exp_wait));
			report($sformatf("%s row %0d", (i < 10) ? "decode" : "arbitration", i), e0);
			step();
		end

		// Corrupted reload then reset
		e0 = errors;
		cpu_bus_i.rd_n   = 1'b1;
		cpu_bus_i.wr_n   = 1'b1;
		cpu_bus_i.iorq_n = 1'b1;
		cpu_bus_i.mreq_n = 1'b1;
		dl_i = '0;
		er_i = '0;
		mem[2] = 8'h5B;
		reset_key_i = 1'b1;
		step();
		reset_key_i = 1'b0;
		repeat (10) step();
		check_val("sys_rst_n_o", 64'(sys_rst_n_o), 64'd1);
		check_val("sig_ok_o", 64'(sig_ok_o), 64'd0);
		report("signature corrupt", e0);

		$display("tests %0d, failed %0d, check errors %0d, property failures %0d", tests,
			failed, errors, dut0.props0.fail_cnt);
		if (errors == 0 && dut0.props0.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* test/lm80c_glue_props.sv */
// Bound checks on the glue top. Sampled on the rising clock, quiet while arst_n_i is low.
// The CPU owns the memory port only when no other writer and no checker is busy.
`timescale 1ns/100ps
`default_nettype none

module lm80c_glue_props import lm80c_pkg::*; (
	input wire       CLOCK,
	input wire       arst_n_i,
	input cpu_bus_t  cpu_bus_i,
	input mem_wr_t   dl_i,
	input mem_wr_t   er_i,
	input wire       chk_busy_i,   // Boot checker holds the port
	input chip_sel_t chip_sel_o,
	input mem_req_t  mem_req_o,
	input wire       cpu_wait_o
);

	logic cpu_owns;       // No other source on the port
	int   fail_cnt = 0;   // Property failures so far

	assign cpu_owns = ~dl_i.busy & ~er_i.busy & ~chk_busy_i;

	// Downloader always stalls the CPU
	wait_during_download: assert property (@(posedge CLOCK) disable iff (!arst_n_i)
		dl_i.busy |-> cpu_wait_o)
		else begin
			fail_cnt++;
			$error("cpu_wait_o low while downloader busy");
		end

	// Video read and write strobes exclusive
	vdp_strobes_exclusive: assert property (@(posedge CLOCK) disable iff (!arst_n_i)
		!(!chip_sel_o.vdp_csr_n && !chip_sel_o.vdp_csw_n))
		else begin
			fail_cnt++;
			$error("both video strobes low");
		end

	// Lower half is ROM for the CPU
	no_rom_write: assert property (@(posedge CLOCK) disable iff (!arst_n_i)
		(cpu_owns && !cpu_bus_i.addr.mem.ram) |-> !mem_req_o.we)
		else begin
			fail_cnt++;
			$error("CPU write enable into lower half");
		end

endmodule

`default_nettype wire

/* hdl/lm80c_glue.sv */
// LM80C glue top. Single clock domain, CPU cores and SDRAM controller live outside.
// sys_rst_n_o is the reset for the CPU and the peripheral cores.
`timescale 1ns/100ps
`default_nettype none

module lm80c_glue import lm80c_pkg::*; (
	input  wire        CLOCK,
	input  wire        arst_n_i,      // Async board reset

	// CPU side
	input  cpu_bus_t   cpu_bus_i,
	output logic [7:0] cpu_din_o,     // Read data back to the CPU
	output logic       cpu_wait_o,    // Stall request to the CPU

	// Peripheral chips
	input  dev_rdata_t dev_rdata_i,
	output chip_sel_t  chip_sel_o,

	// Memory writers outside the glue
	input  mem_wr_t    dl_i,          // ROM downloader
	input  mem_wr_t    er_i,          // Memory eraser
	input  wire        boot_done_i,   // Boot ROM loaded
	input  wire        reset_key_i,   // Keyboard reset key, active high

	// SDRAM controller
	input  wire  [7:0] mem_rdata_i,
	output mem_req_t   mem_req_o,

	// System status
	output logic       sys_rst_n_o,
	output logic       sig_ok_o       // Boot signature matched
);

	mem_wr_t chk_req;   // Boot checker read port, never writes

	// I/O strobes and read return
	io_decode io_decode0 (
		.cpu_bus_i   (cpu_bus_i),
		.dev_rdata_i (dev_rdata_i),
		.mem_rdata_i (mem_rdata_i),
		.chip_sel_o  (chip_sel_o),
		.cpu_din_o   (cpu_din_o)
	);

	// Memory port owner select
	mem_arbiter mem_arbiter0 (
		.cpu_bus_i   (cpu_bus_i),
		.dl_i        (dl_i),
		.er_i        (er_i),
		.chk_i       (chk_req),
		.boot_done_i (boot_done_i),
		.mem_req_o   (mem_req_o),
		.cpu_wait_o  (cpu_wait_o)
	);

	// System reset and signature check
	boot_check boot_check0 (
		.CLOCK       (CLOCK),
		.arst_n_i    (arst_n_i),
		.boot_done_i (boot_done_i),
		.reset_key_i (reset_key_i),
		.mem_rdata_i (mem_rdata_i),
		.chk_o       (chk_req),
		.sys_rst_n_o (sys_rst_n_o),
		.sig_ok_o    (sig_ok_o)
	);

endmodule

`default_nettype wire

/* mem/boot_check.sv */
// System reset register and boot signature reader for addresses 0 to 3.
// Data is sampled in the cycle its address is presented, so memory must answer combinationally.
`timescale 1ns/100ps
`default_nettype none

module boot_check import lm80c_pkg::*; (
	input  wire        CLOCK,
	input  wire        arst_n_i,
	input  wire        boot_done_i,   // Boot ROM loaded
	input  wire        reset_key_i,   // Reset key pressed
	input  wire  [7:0] mem_rdata_i,
	output mem_wr_t    chk_o,         // Read-only memory port
	output logic       sys_rst_n_o,
	output logic       sig_ok_o
);

	localparam int IDX_W = $clog2(SIG_LEN);
	localparam int CNT_W = $clog2(SIG_LEN + 1);

	logic             busy;        // Checker owns the memory port
	logic             done;        // All bytes read
	logic [IDX_W-1:0] idx;         // Byte being read
	logic [CNT_W-1:0] match_cnt;   // Bytes that agreed
	logic [7:0]       exp_byte;

	// Reset held while booting or with the key down
	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i)
			sys_rst_n_o <= 1'b0;
		else
			sys_rst_n_o <= boot_done_i & ~reset_key_i;
	end

	// Expected byte, address 0 in the top byte
	assign exp_byte = SIG_BYTES[8*(SIG_LEN-1-int'(idx)) +: 8];

	// Signature walk, restarts on every system reset
	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			idx       <= '0;
			match_cnt <= '0;
			sig_ok_o  <= 1'b0;
		end else if (!sys_rst_n_o) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			idx       <= '0;
			match_cnt <= '0;
			sig_ok_o  <= 1'b0;
		end else begin
			if (!busy && !done) begin
				busy <= 1'b1;   // Grab the port
			end else if (busy) begin
				if (mem_rdata_i == exp_byte)
					match_cnt <= match_cnt + 1'b1;
				idx <= idx + 1'b1;
				if (idx == IDX_W'(SIG_LEN - 1)) begin
					busy <= 1'b0;   // Last byte sampled
					done <= 1'b1;
				end
			end
			// Sticky until the next reset
			if (done && match_cnt == CNT_W'(SIG_LEN))
				sig_ok_o <= 1'b1;
		end
	end

	// Read-only request to the arbiter
	always_comb begin
		chk_o.busy = busy;
		chk_o.wr   = 1'b0;
		chk_o.addr = MEM_AW'(idx);
		chk_o.data = 8'h00;
	end

endmodule

`default_nettype wire

/* mem/mem_arbiter.sv */
// Fixed priority on the one memory port: downloader, eraser, boot checker, CPU.
// Combinational; the CPU is held off by cpu_wait_o only, no back-pressure.
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import lm80c_pkg::*; (
	input  cpu_bus_t cpu_bus_i,
	input  mem_wr_t  dl_i,          // ROM downloader
	input  mem_wr_t  er_i,          // Memory eraser
	input  mem_wr_t  chk_i,         // Boot checker
	input  wire      boot_done_i,
	output mem_req_t mem_req_o,
	output logic     cpu_wait_o
);

	mem_req_t cpu_req;   // CPU request before arbitration

	// Writer request, reads always enabled
	function automatic mem_req_t writer_req(input mem_wr_t w);
		mem_req_t r;
		r.addr = w.addr;
		r.din  = w.data;
		r.we   = w.wr;
		r.oe   = 1'b1;
		return r;
	endfunction

	// CPU request, writes land only in the RAM half
	always_comb begin
		cpu_req.addr = {{(MEM_AW-16){1'b0}}, cpu_bus_i.addr};   // Zero-extended
		cpu_req.din  = cpu_bus_i.dout;
		cpu_req.we   = ~cpu_bus_i.wr_n & ~cpu_bus_i.mreq_n & cpu_bus_i.addr.mem.ram;
		cpu_req.oe   = ~cpu_bus_i.rd_n & ~cpu_bus_i.mreq_n;
	end

	// Priority select
	always_comb begin
		if (dl_i.busy)
			mem_req_o = writer_req(dl_i);
		else if (er_i.busy)
			mem_req_o = writer_req(er_i);
		else if (chk_i.busy)
			mem_req_o = writer_req(chk_i);
		else
			mem_req_o = cpu_req;
	end

	// CPU stalls until boot is done and the port is free
	assign cpu_wait_o = ~boot_done_i | dl_i.busy | er_i.busy | chk_i.busy;

endmodule

`default_nettype wire

/* bus/io_decode.sv */
// Z80 I/O decode on A[7:4] with level strobes only, no handshake.
// Purely combinational; memory data is returned when no I/O device answers.
`timescale 1ns/100ps
`default_nettype none

module io_decode import lm80c_pkg::*; (
	input  cpu_bus_t   cpu_bus_i,
	input  dev_rdata_t dev_rdata_i,
	input  wire  [7:0] mem_rdata_i,    // SDRAM read byte
	output chip_sel_t  chip_sel_o,
	output logic [7:0] cpu_din_o
);

	logic io_cycle;   // IORQ without MREQ
	dev_e dev;        // Selected device
	logic rd;         // CPU strobes, active high
	logic wr;

	assign io_cycle = ~cpu_bus_i.iorq_n & cpu_bus_i.mreq_n;
	assign rd       = ~cpu_bus_i.rd_n;
	assign wr       = ~cpu_bus_i.wr_n;

	// Device from the port nibble
	always_comb begin
		dev = DEV_NONE;
		if (io_cycle) begin
			case (cpu_bus_i.addr.io.dev)
				4'h0:    dev = DEV_PIO;
				4'h1:    dev = DEV_CTC;
				4'h2:    dev = DEV_SIO;
				4'h3:    dev = DEV_VDP;
				4'h4:    dev = DEV_PSG;
				default: dev = DEV_NONE;   // Unmapped ports
			endcase
		end
	end

	// Chip strobes
	always_comb begin
		chip_sel_o.ctc_ce_n  = ~(dev == DEV_CTC);
		chip_sel_o.vdp_csr_n = ~((dev == DEV_VDP) & rd);
		chip_sel_o.vdp_csw_n = ~((dev == DEV_VDP) & wr);
		chip_sel_o.psg_bdir  = (dev == DEV_PSG) & wr;   // Latch or write
		// BC high with A0 low selects the address latch
		chip_sel_o.psg_bc    = (dev == DEV_PSG) & ~cpu_bus_i.addr.io.reg_idx[0];
		chip_sel_o.vdp_mode  = cpu_bus_i.addr.io.reg_idx[1];   // A1 straight through
	end

	// Read return to the CPU
	always_comb begin
		case (dev)
			DEV_CTC: cpu_din_o = dev_rdata_i.ctc;
			DEV_VDP: cpu_din_o = dev_rdata_i.vdp;
			DEV_PSG: cpu_din_o = dev_rdata_i.psg;
			DEV_PIO,
			DEV_SIO: cpu_din_o = 8'h00;    // No PIO or SIO in this build
			default: cpu_din_o = mem_rdata_i;
		endcase
	end

endmodule

`default_nettype wire

/* common/lm80c_pkg.sv */
// Shared types for the LM80C system glue. Bus strobes are active low as on the Z80.
// Memory space is 25 bits wide; the CPU reaches only the lowest 64K of it.
`default_nettype none

package lm80c_pkg;

	localparam int MEM_AW  = 25;  // SDRAM byte address width
	localparam int SIG_LEN = 4;   // Boot signature length in bytes

	// Boot signature, byte at address 0 in the top byte
	localparam logic [8*SIG_LEN-1:0] SIG_BYTES = 32'hF3C35A02;

	// One CPU address word, read as I/O port or as memory address
	typedef union packed {
		struct packed {
			logic [7:0] unused_hi;   // Upper byte ignored in I/O cycles
			logic [3:0] dev;         // Device nibble A[7:4]
			logic [1:0] unused_mid;
			logic [1:0] reg_idx;     // Register select A[1:0]
		} io;
		struct packed {
			logic        ram;        // A15, upper half is RAM
			logic [14:0] ofs;
		} mem;
	} cpu_addr_u;

	// Z80 bus as seen by the glue
	typedef struct packed {
		cpu_addr_u  addr;
		logic [7:0] dout;     // CPU write data
		logic       rd_n;
		logic       wr_n;
		logic       iorq_n;
		logic       mreq_n;
	} cpu_bus_t;

	// Decoded I/O device, values match the address nibble
	typedef enum logic [2:0] {
		DEV_PIO  = 3'd0,
		DEV_CTC  = 3'd1,
		DEV_SIO  = 3'd2,
		DEV_VDP  = 3'd3,
		DEV_PSG  = 3'd4,
		DEV_NONE = 3'd7
	} dev_e;

	// Read bytes returned by the peripheral chips
	typedef struct packed {
		logic [7:0] ctc;
		logic [7:0] vdp;
		logic [7:0] psg;
	} dev_rdata_t;

	// Strobes to the peripheral chips
	typedef struct packed {
		logic ctc_ce_n;    // Timer chip enable
		logic vdp_csr_n;   // Video read strobe
		logic vdp_csw_n;   // Video write strobe
		logic psg_bdir;    // Sound chip bus direction
		logic psg_bc;      // Sound chip bus control
		logic vdp_mode;    // Video register/data select, A1
	} chip_sel_t;

	// External memory writer, downloader or eraser style
	typedef struct packed {
		logic              busy;   // Holds the memory port
		logic              wr;
		logic [MEM_AW-1:0] addr;
		logic [7:0]        data;
	} mem_wr_t;

	// Request to the SDRAM controller
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [7:0]        din;
		logic              we;
		logic              oe;
	} mem_req_t;

endpackage

`default_nettype wire
